/* source/rv_decode_pkg.sv */
/* Shared widths, opcodes and ALU select codes for the RV32I decoder front end.
   Only the OP, OP-IMM, LUI and AUIPC major opcodes are known here.
   All other opcodes decode as illegal */
package rv_decode_pkg;

  //////////////////////////////////////////////////
  // Widths and basic types
  //////////////////////////////////////////////////
  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int ALU_OP_WIDTH   = 4;

  typedef logic [DATA_WIDTH-1:0]     word_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [ALU_OP_WIDTH-1:0]   alu_op_t;  // {instr[30], funct3}

  localparam alu_op_t ALU_OP_ADD = 4'b0000;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////
  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_OP    = 7'b0110011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI   = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;

  // Shift-immediate forms of OP-IMM
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;

  // Decoded instruction class
  typedef enum logic [2:0] {
    OP_CLASS_REG     = 3'd0,  // Register-register ALU op
    OP_CLASS_IMM     = 3'd1,  // Register-immediate ALU op
    OP_CLASS_LUI     = 3'd2,
    OP_CLASS_AUIPC   = 3'd3,  // Operand A is the PC
    OP_CLASS_ILLEGAL = 3'd4
  } op_class_e;

endpackage

/* source/rv_imm_gen.sv */
/* Immediate builder for the supported classes. Malformed shift forms arrive
   already classed illegal and give a zero immediate */
`timescale 1ns/1ps

module rv_imm_gen (
  input  rv_decode_pkg::word_t     instr_i,
  input  rv_decode_pkg::op_class_e class_i,
  output rv_decode_pkg::word_t     imm_o
);

  rv_decode_pkg::word_t i_imm;
  rv_decode_pkg::word_t shamt_imm;
  rv_decode_pkg::word_t u_imm;
  logic                 is_shift;

  // I-type, sign extended from bit 31
  assign i_imm = {{(rv_decode_pkg::DATA_WIDTH - 12){instr_i[31]}}, instr_i[31:20]};

  // Shift amount, never sign extended
  assign shamt_imm = {{(rv_decode_pkg::DATA_WIDTH - 5){1'b0}}, instr_i[24:20]};

  assign u_imm = {instr_i[31:12], 12'b0000_0000_0000};  // Upper 20 bits

  assign is_shift = (instr_i[14:12] == rv_decode_pkg::FUNCT3_SLL) ||
                    (instr_i[14:12] == rv_decode_pkg::FUNCT3_SRL_SRA);

  always_comb begin
    case (class_i)
      rv_decode_pkg::OP_CLASS_IMM: begin
        imm_o = is_shift ? shamt_imm : i_imm;
      end
      rv_decode_pkg::OP_CLASS_LUI,
      rv_decode_pkg::OP_CLASS_AUIPC: begin
        imm_o = u_imm;
      end
      default: begin
        imm_o = '0;  // OP and illegal carry no immediate
      end
    endcase
  end

endmodule

/* source/rv_op_decode.sv */
/* Combinational class and ALU control decode.
   Unused register fields are driven as zero, illegal items use no register
   and have rd zero, so they never take part in a hazard */
`timescale 1ns/1ps

module rv_op_decode (
  input  rv_decode_pkg::word_t      instr_i,
  output rv_decode_pkg::op_class_e  class_o,
  output rv_decode_pkg::alu_op_t    alu_sel_o,
  output rv_decode_pkg::reg_addr_t  rs1_o,
  output rv_decode_pkg::reg_addr_t  rs2_o,
  output rv_decode_pkg::reg_addr_t  rd_o,
  output logic                      uses_rs1_o,
  output logic                      uses_rs2_o,
  output logic                      is_imm_o,
  output logic                      use_pc_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_shift;
  logic       shift_ok;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign is_shift = (funct3 == rv_decode_pkg::FUNCT3_SLL) ||
                    (funct3 == rv_decode_pkg::FUNCT3_SRL_SRA);
  // Upper bits zero, or only bit 30 set for the arithmetic form
  assign shift_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

  always_comb begin
    class_o    = rv_decode_pkg::OP_CLASS_ILLEGAL;
    alu_sel_o  = rv_decode_pkg::ALU_OP_ADD;
    rs1_o      = '0;
    rs2_o      = '0;
    rd_o       = '0;
    uses_rs1_o = 1'b0;
    uses_rs2_o = 1'b0;
    is_imm_o   = 1'b0;
    use_pc_o   = 1'b0;

    case (opcode)
      rv_decode_pkg::OPCODE_OP: begin
        class_o    = rv_decode_pkg::OP_CLASS_REG;
        alu_sel_o  = {instr_i[30], funct3};
        rs1_o      = instr_i[19:15];
        rs2_o      = instr_i[24:20];
        rd_o       = instr_i[11:7];
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
      end
      rv_decode_pkg::OPCODE_OPIMM: begin
        if (!is_shift || shift_ok) begin  // Malformed shift stays illegal
          class_o    = rv_decode_pkg::OP_CLASS_IMM;
          alu_sel_o  = is_shift ? {instr_i[30], funct3} : {1'b0, funct3};
          rs1_o      = instr_i[19:15];
          rd_o       = instr_i[11:7];
          uses_rs1_o = 1'b1;
          is_imm_o   = 1'b1;
        end
      end
      rv_decode_pkg::OPCODE_LUI: begin
        class_o  = rv_decode_pkg::OP_CLASS_LUI;  // x0 + imm
        rd_o     = instr_i[11:7];
        is_imm_o = 1'b1;
      end
      rv_decode_pkg::OPCODE_AUIPC: begin
        class_o  = rv_decode_pkg::OP_CLASS_AUIPC;
        rd_o     = instr_i[11:7];
        is_imm_o = 1'b1;
        use_pc_o = 1'b1;  // PC + imm
      end
      default: begin
      end
    endcase
  end

endmodule

/* source/rv_decode_stage.sv */
/* First pipeline stage. Decodes the incoming word and registers the item.
   While stall_i is high the register holds and ready_o is low, so the source
   must keep instr_i stable */
`timescale 1ns/1ps

module rv_decode_stage (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  rv_decode_pkg::word_t      instr_i,
  input  logic                      instr_valid_i,
  input  logic                      stall_i,
  output logic                      ready_o,
  output logic                      item_valid_o,
  output rv_decode_pkg::op_class_e  class_o,
  output rv_decode_pkg::alu_op_t    alu_sel_o,
  output rv_decode_pkg::reg_addr_t  rs1_o,
  output rv_decode_pkg::reg_addr_t  rs2_o,
  output rv_decode_pkg::reg_addr_t  rd_o,
  output logic                      uses_rs1_o,
  output logic                      uses_rs2_o,
  output logic                      is_imm_o,
  output logic                      use_pc_o,
  output rv_decode_pkg::word_t      imm_o
);

  rv_decode_pkg::op_class_e  class_d;
  rv_decode_pkg::alu_op_t    alu_sel_d;
  rv_decode_pkg::reg_addr_t  rs1_d;
  rv_decode_pkg::reg_addr_t  rs2_d;
  rv_decode_pkg::reg_addr_t  rd_d;
  logic                      uses_rs1_d;
  logic                      uses_rs2_d;
  logic                      is_imm_d;
  logic                      use_pc_d;
  rv_decode_pkg::word_t      imm_d;

  rv_op_decode u_op_decode (
    .instr_i    (instr_i),
    .class_o    (class_d),
    .alu_sel_o  (alu_sel_d),
    .rs1_o      (rs1_d),
    .rs2_o      (rs2_d),
    .rd_o       (rd_d),
    .uses_rs1_o (uses_rs1_d),
    .uses_rs2_o (uses_rs2_d),
    .is_imm_o   (is_imm_d),
    .use_pc_o   (use_pc_d)
  );

  rv_imm_gen u_imm_gen (
    .instr_i (instr_i),
    .class_i (class_d),
    .imm_o   (imm_d)
  );

  assign ready_o = ~stall_i;  // Hazard stall is the only back-pressure

  //////////////////////////////////////////////////
  // Item register
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      item_valid_o <= 1'b0;
    end else if (!stall_i) begin
      item_valid_o <= instr_valid_i;  // Bubble when nothing accepted
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      class_o    <= class_d;
      alu_sel_o  <= alu_sel_d;
      rs1_o      <= rs1_d;
      rs2_o      <= rs2_d;
      rd_o       <= rd_d;
      uses_rs1_o <= uses_rs1_d;
      uses_rs2_o <= uses_rs2_d;
      is_imm_o   <= is_imm_d;
      use_pc_o   <= use_pc_d;
      imm_o      <= imm_d;
    end
  end

endmodule

/* source/rv_hazard_stage.sv */
/* Second pipeline stage with the read-after-write check against the rd issued
   in the previous cycle. A hazard inserts STALL_CYCLES bubbles (1 to 3).
   Issue outputs are zero in every cycle without an issue */
`timescale 1ns/1ps

module rv_hazard_stage #(
  parameter int STALL_CYCLES = 1
) (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      item_valid_i,
  input  rv_decode_pkg::op_class_e  class_i,
  input  rv_decode_pkg::alu_op_t    alu_sel_i,
  input  rv_decode_pkg::reg_addr_t  rs1_i,
  input  rv_decode_pkg::reg_addr_t  rs2_i,
  input  rv_decode_pkg::reg_addr_t  rd_i,
  input  logic                      uses_rs1_i,
  input  logic                      uses_rs2_i,
  input  logic                      is_imm_i,
  input  logic                      use_pc_i,
  input  rv_decode_pkg::word_t      imm_i,
  output logic                      stall_o,
  output logic                      issue_o,
  output logic                      illegal_o,
  output rv_decode_pkg::alu_op_t    alu_sel_o,
  output rv_decode_pkg::reg_addr_t  alu_dest_o,
  output rv_decode_pkg::reg_addr_t  rf_addr_a_o,
  output rv_decode_pkg::reg_addr_t  rf_addr_b_o,
  output logic                      is_imm_o,
  output logic                      use_pc_o,
  output rv_decode_pkg::word_t      imm_o
);

  localparam int CNT_WIDTH = 2;  // Enough for up to 3 bubbles

  rv_decode_pkg::reg_addr_t prev_rd_q;
  logic [CNT_WIDTH-1:0]     bubble_cnt_q;
  logic                     rs1_hit;
  logic                     rs2_hit;
  logic                     hazard;
  logic                     issue_d;
  logic                     illegal_d;

  //////////////////////////////////////////////////
  // Hazard detection
  //////////////////////////////////////////////////
  assign rs1_hit = uses_rs1_i && (rs1_i != '0) && (rs1_i == prev_rd_q);
  assign rs2_hit = uses_rs2_i && (rs2_i != '0) && (rs2_i == prev_rd_q);
  assign hazard  = item_valid_i && (rs1_hit || rs2_hit);

  // First bubble from the hazard itself, the rest from the counter
  assign stall_o = hazard || (bubble_cnt_q != '0);

  assign issue_d   = item_valid_i && !stall_o &&
                     (class_i != rv_decode_pkg::OP_CLASS_ILLEGAL);
  assign illegal_d = item_valid_i && !stall_o &&
                     (class_i == rv_decode_pkg::OP_CLASS_ILLEGAL);

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      bubble_cnt_q <= '0;
    end else if (bubble_cnt_q != '0) begin
      bubble_cnt_q <= bubble_cnt_q - 1'b1;
    end else if (hazard) begin
      bubble_cnt_q <= CNT_WIDTH'(STALL_CYCLES - 1);
    end
  end

  // Only an issued instruction leaves an rd behind
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_rd_q <= '0;
    end else begin
      prev_rd_q <= issue_d ? rd_i : '0;
    end
  end

  //////////////////////////////////////////////////
  // Issue registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      issue_o     <= 1'b0;
      illegal_o   <= 1'b0;
      alu_sel_o   <= '0;
      alu_dest_o  <= '0;
      rf_addr_a_o <= '0;
      rf_addr_b_o <= '0;
      is_imm_o    <= 1'b0;
      use_pc_o    <= 1'b0;
      imm_o       <= '0;
    end else begin
      issue_o     <= issue_d;    // Writeback strobe
      illegal_o   <= illegal_d;
      alu_sel_o   <= issue_d ? alu_sel_i : '0;
      alu_dest_o  <= issue_d ? rd_i : '0;
      rf_addr_a_o <= issue_d ? rs1_i : '0;
      rf_addr_b_o <= issue_d ? rs2_i : '0;
      is_imm_o    <= issue_d && is_imm_i;
      use_pc_o    <= issue_d && use_pc_i;
      imm_o       <= issue_d ? imm_i : '0;
    end
  end

endmodule

/* source/rv_decode_top.sv */
/* RV32I decoder front end for OP, OP-IMM, LUI and AUIPC.
   Results appear 2 cycles after acceptance, 2 + STALL_CYCLES on a hazard.
   No downstream ready, the issue slot cannot be held */
`timescale 1ns/1ps

module rv_decode_top #(
  parameter int STALL_CYCLES = 1  // Bubbles per hazard, 1 to 3
) (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  rv_decode_pkg::word_t      instr_i,
  input  logic                      instr_valid_i,
  output logic                      ready_o,
  output logic                      issue_o,
  output logic                      illegal_o,
  output rv_decode_pkg::alu_op_t    alu_sel_o,
  output rv_decode_pkg::reg_addr_t  alu_dest_o,
  output rv_decode_pkg::reg_addr_t  rf_addr_a_o,
  output rv_decode_pkg::reg_addr_t  rf_addr_b_o,
  output logic                      is_imm_o,
  output logic                      use_pc_o,
  output rv_decode_pkg::word_t      imm_o
);

  // Decode stage to hazard stage
  logic                      item_valid;
  rv_decode_pkg::op_class_e  item_class;
  rv_decode_pkg::alu_op_t    item_alu_sel;
  rv_decode_pkg::reg_addr_t  item_rs1;
  rv_decode_pkg::reg_addr_t  item_rs2;
  rv_decode_pkg::reg_addr_t  item_rd;
  logic                      item_uses_rs1;
  logic                      item_uses_rs2;
  logic                      item_is_imm;
  logic                      item_use_pc;
  rv_decode_pkg::word_t      item_imm;
  logic                      stall;

  rv_decode_stage u_decode_stage (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall),
    .ready_o       (ready_o),
    .item_valid_o  (item_valid),
    .class_o       (item_class),
    .alu_sel_o     (item_alu_sel),
    .rs1_o         (item_rs1),
    .rs2_o         (item_rs2),
    .rd_o          (item_rd),
    .uses_rs1_o    (item_uses_rs1),
    .uses_rs2_o    (item_uses_rs2),
    .is_imm_o      (item_is_imm),
    .use_pc_o      (item_use_pc),
    .imm_o         (item_imm)
  );

  rv_hazard_stage #(
    .STALL_CYCLES (STALL_CYCLES)
  ) u_hazard_stage (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .item_valid_i (item_valid),
    .class_i      (item_class),
    .alu_sel_i    (item_alu_sel),
    .rs1_i        (item_rs1),
    .rs2_i        (item_rs2),
    .rd_i         (item_rd),
    .uses_rs1_i   (item_uses_rs1),
    .uses_rs2_i   (item_uses_rs2),
    .is_imm_i     (item_is_imm),
    .use_pc_i     (item_use_pc),
    .imm_i        (item_imm),
    .stall_o      (stall),
    .issue_o      (issue_o),
    .illegal_o    (illegal_o),
    .alu_sel_o    (alu_sel_o),
    .alu_dest_o   (alu_dest_o),
    .rf_addr_a_o  (rf_addr_a_o),
    .rf_addr_b_o  (rf_addr_b_o),
    .is_imm_o     (is_imm_o),
    .use_pc_o     (use_pc_o),
    .imm_o        (imm_o)
  );

endmodule

/* tests/rv_decode_ref.svh */
/* Reference decode of one RV32I word into the expected issue slot.
   Included inside the testbench module. Fields an instruction does not use
   are expected as zero, and an illegal word expects an all-zero slot */
`ifndef RV_DECODE_REF_SVH
`define RV_DECODE_REF_SVH

// Same bit order as the top-level outputs
typedef struct packed {
  logic        issue;
  logic        illegal;
  logic [3:0]  alu_sel;
  logic [4:0]  alu_dest;
  logic [4:0]  rf_addr_a;
  logic [4:0]  rf_addr_b;
  logic        is_imm;
  logic        use_pc;
  logic [31:0] imm;
} exp_item_t;

function automatic exp_item_t ref_decode(input logic [31:0] instr);
  exp_item_t  item;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shift;
  item   = '0;
  funct3 = instr[14:12];
  funct7 = instr[31:25];
  shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
  item.illegal = 1'b1;  // Until an opcode below claims it
  case (instr[6:0])
    7'h33: begin  // OP
      item.illegal   = 1'b0;
      item.issue     = 1'b1;
      item.alu_sel   = {instr[30], funct3};
      item.alu_dest  = instr[11:7];
      item.rf_addr_a = instr[19:15];
      item.rf_addr_b = instr[24:20];
    end
    7'h13: begin  // OP-IMM
      if (!shift || funct7 == 7'h00 || funct7 == 7'h20) begin
        item.illegal   = 1'b0;
        item.issue     = 1'b1;
        item.alu_sel   = shift ? {instr[30], funct3} : {1'b0, funct3};
        item.alu_dest  = instr[11:7];
        item.rf_addr_a = instr[19:15];
        item.is_imm    = 1'b1;
        item.imm       = shift ? {27'd0, instr[24:20]} : {{20{instr[31]}}, instr[31:20]};
      end
    end
    7'h37, 7'h17: begin  // LUI, AUIPC
      item.illegal  = 1'b0;
      item.issue    = 1'b1;
      item.alu_dest = instr[11:7];
      item.is_imm   = 1'b1;
      item.use_pc   = (instr[6:0] == 7'h17);
      item.imm      = {instr[31:12], 12'd0};
    end
    default: begin
    end
  endcase
  return item;
endfunction

`endif

/* tests/tb_rv_decode.sv */
/* Testbench for rv_decode_top with STALL_CYCLES set to 2.
   Inputs change on the falling edge and results are sampled there too.
   Latency is counted from the falling edge where the word is accepted */
`timescale 1ns/1ps

module tb_rv_decode;

  `include "rv_decode_ref.svh"

  localparam int STALL_CYCLES = 2;
  localparam int WAIT_LIMIT   = 20;   // Cycles before a wait gives up
  localparam int NUM_RANDOM   = 200;

  logic        clk_i;
  logic        rstn_i;
  logic [31:0] instr_i;
  logic        instr_valid_i;
  logic        ready_o;
  logic        issue_o;
  logic        illegal_o;
  logic [3:0]  alu_sel_o;
  logic [4:0]  alu_dest_o;
  logic [4:0]  rf_addr_a_o;
  logic [4:0]  rf_addr_b_o;
  logic        is_imm_o;
  logic        use_pc_o;
  logic [31:0] imm_o;

  integer      seed;
  int          cycle_cnt = 0;
  int          mismatch_cnt = 0;
  int          other_err_cnt = 0;
  int          last_wait;           // Ready-low cycles seen by the last send
  logic [4:0]  model_prev_rd;       // rd the next accepted item is compared with
  exp_item_t   actual;
  exp_item_t   exp_q[$];
  int          due_q[$];
  string       name_q[$];

  rv_decode_top #(
    .STALL_CYCLES (STALL_CYCLES)
  ) dut (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .ready_o       (ready_o),
    .issue_o       (issue_o),
    .illegal_o     (illegal_o),
    .alu_sel_o     (alu_sel_o),
    .alu_dest_o    (alu_dest_o),
    .rf_addr_a_o   (rf_addr_a_o),
    .rf_addr_b_o   (rf_addr_b_o),
    .is_imm_o      (is_imm_o),
    .use_pc_o      (use_pc_o),
    .imm_o         (imm_o)
  );

  assign actual = {issue_o, illegal_o, alu_sel_o, alu_dest_o, rf_addr_a_o,
                   rf_addr_b_o, is_imm_o, use_pc_o, imm_o};

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual_v);
    if (expected !== actual_v) begin
      mismatch_cnt++;
      $display("Error: %s expected %h actual %h", name, expected, actual_v);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // Hazard rule on the reference item's register fields
  function automatic bit depends_on_prev(input exp_item_t item, input logic [4:0] prev_rd);
    return ((item.rf_addr_a != 5'd0) && (item.rf_addr_a == prev_rd)) ||
           ((item.rf_addr_b != 5'd0) && (item.rf_addr_b == prev_rd));
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_decode_pkg::OPCODE_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_decode_pkg::OPCODE_OPIMM};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opcode, input logic [19:0] imm,
                                        input logic [4:0] rd);
    return {imm, rd, opcode};
  endfunction

  // Legal OP, OP-IMM, LUI or AUIPC with random fields
  function automatic logic [31:0] random_instr();
    logic [31:0] kind;
    logic [31:0] r;
    logic [6:0]  f7;
    kind = $random(seed);
    r    = $random(seed);
    f7   = r[31] ? 7'h20 : 7'h00;
    case (kind[1:0])
      2'd0: return enc_r(f7, r[24:20], r[19:15], r[14:12], r[11:7]);
      2'd1: begin
        if (r[13:12] == 2'b01) begin  // funct3 001 or 101 is a shift
          return enc_i({f7, r[24:20]}, r[19:15], r[14:12], r[11:7]);
        end
        return enc_i(r[31:20], r[19:15], r[14:12], r[11:7]);
      end
      2'd2: return enc_u(rv_decode_pkg::OPCODE_LUI, r[31:12], r[11:7]);
      default: return enc_u(rv_decode_pkg::OPCODE_AUIPC, r[31:12], r[11:7]);
    endcase
  endfunction

  // Entered and left on a falling edge
  task automatic send_instr(input string name, input logic [31:0] instr);
    exp_item_t exp;
    int        due;
    instr_i       = instr;
    instr_valid_i = 1'b1;
    last_wait     = 0;
    while (!ready_o) begin
      @(negedge clk_i);
      last_wait++;
      if (last_wait > WAIT_LIMIT) begin
        other_err_cnt++;
        $display("Timeout: ready_o stayed low while sending %s", name);
        finish_run();
      end
    end
    exp = ref_decode(instr);
    due = cycle_cnt + 2;
    if (depends_on_prev(exp, model_prev_rd)) begin
      due = due + STALL_CYCLES;
    end
    model_prev_rd = exp.issue ? exp.alu_dest : 5'd0;
    exp_q.push_back(exp);
    due_q.push_back(due);
    name_q.push_back(name);
    @(negedge clk_i);
    instr_valid_i = 1'b0;
  endtask

  task automatic idle_cycle();
    instr_valid_i = 1'b0;
    if (ready_o) begin
      model_prev_rd = 5'd0;  // A bubble reaches the hazard stage
    end
    @(negedge clk_i);
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      idle_cycle();
      waited++;
      if (waited > WAIT_LIMIT) begin
        other_err_cnt++;
        $display("Timeout: %0d results never came out", exp_q.size());
        finish_run();
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////
  initial begin : compare_results
    exp_item_t expected;
    string     name;
    int        due;
    forever begin
      @(negedge clk_i);
      if (rstn_i && (issue_o || illegal_o)) begin
        if (exp_q.size() == 0) begin
          other_err_cnt++;
          $display("Unexpected result pulse at cycle %0d with nothing outstanding", cycle_cnt);
        end else begin
          expected = exp_q.pop_front();
          due      = due_q.pop_front();
          name     = name_q.pop_front();
          check_value(name, expected, actual);
          check_value({name, " latency"}, due, cycle_cnt);
        end
      end else if (rstn_i) begin
        check_value("quiet outputs", '0, actual);  // Slot must be all zero
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin : stimulus
    logic [6:0]  bad_ops [0:6];
    logic [31:0] r;
    int          i;
    seed          = 88;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    rstn_i        = 1'b0;
    model_prev_rd = 5'd0;
    bad_ops = '{7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h73, 7'h0f};
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;

    // Idle after reset
    for (i = 0; i < 4; i++) begin
      check_value("reset ready_o", 1, ready_o);
      check_value("reset pulses", 0, {issue_o, illegal_o});
      idle_cycle();
    end

    for (i = 0; i < NUM_RANDOM; i++) begin
      send_instr("random", random_instr());
    end
    drain_results();

    // Dependent pairs with a follower that waits out the stall
    send_instr("rs1 producer", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
    send_instr("rs1 consumer", enc_r(7'h20, 5'd3, 5'd5, 3'b000, 5'd6));
    send_instr("rs1 follower", enc_u(rv_decode_pkg::OPCODE_LUI, 20'h12345, 5'd7));
    check_value("rs1 stall length", STALL_CYCLES, last_wait);
    send_instr("rs2 producer", enc_i(12'h7ff, 5'd3, 3'b000, 5'd9));
    send_instr("rs2 consumer", enc_r(7'h00, 5'd9, 5'd4, 3'b100, 5'd10));
    send_instr("rs2 follower", enc_u(rv_decode_pkg::OPCODE_AUIPC, 20'hfffff, 5'd11));
    check_value("rs2 stall length", STALL_CYCLES, last_wait);
    send_instr("imm producer", enc_u(rv_decode_pkg::OPCODE_LUI, 20'h80000, 5'd12));
    send_instr("imm consumer", enc_i(12'h800, 5'd12, 3'b000, 5'd13));
    send_instr("imm follower", enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd14));
    check_value("imm stall length", STALL_CYCLES, last_wait);
    drain_results();

    // Pairs that must not stall
    send_instr("x0 producer", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    send_instr("x0 consumer", enc_i(12'h001, 5'd0, 3'b000, 5'd3));
    send_instr("x0 follower", enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd4));
    check_value("x0 no stall", 0, last_wait);
    send_instr("gap producer", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
    idle_cycle();
    send_instr("gap consumer", enc_i(12'h010, 5'd5, 3'b010, 5'd6));
    send_instr("gap follower", enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd7));
    check_value("gap no stall", 0, last_wait);
    send_instr("lui producer", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
    // Bits 19:15 of this LUI equal the producer rd
    send_instr("lui consumer", enc_u(rv_decode_pkg::OPCODE_LUI, 20'h00028, 5'd8));
    send_instr("lui follower", enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd9));
    check_value("lui no stall", 0, last_wait);
    drain_results();

    // Illegal words with a normal word after each
    for (i = 0; i < 7; i++) begin
      r = $random(seed);
      send_instr("illegal opcode", {r[31:7], bad_ops[i]});
      send_instr("after illegal", enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1));
    end
    send_instr("bad slli", enc_i({7'h01, 5'd3}, 5'd1, rv_decode_pkg::FUNCT3_SLL, 5'd2));
    send_instr("after bad slli", enc_i(12'hf00, 5'd1, 3'b000, 5'd2));
    send_instr("bad srai", enc_i({7'h40, 5'd7}, 5'd1, rv_decode_pkg::FUNCT3_SRL_SRA, 5'd2));
    send_instr("after bad srai", enc_i({7'h20, 5'd7}, 5'd1, rv_decode_pkg::FUNCT3_SRL_SRA, 5'd2));
    send_instr("bad srli", enc_i({7'h21, 5'd1}, 5'd3, rv_decode_pkg::FUNCT3_SRL_SRA, 5'd4));
    send_instr("after bad srli", enc_u(rv_decode_pkg::OPCODE_AUIPC, 20'h00abc, 5'd4));
    drain_results();

    finish_run();
  end

endmodule

/* vlog.f */
+incdir+tests
source/rv_decode_pkg.sv
source/rv_imm_gen.sv
source/rv_op_decode.sv
source/rv_decode_stage.sv
source/rv_hazard_stage.sv
source/rv_decode_top.sv
tests/tb_rv_decode.sv
